// File: source/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// shared code and data memory, in 32-bit words
`define MEM_WORDS 1024

// host registers sit just above the memory window
`define CTRL_ADDR 32'h0000_1000
`define STAT_ADDR 32'h0000_1004
`define CYC_ADDR  32'h0000_1008
`define RET_ADDR  32'h0000_100C

`endif

// File: source/core_pkg.sv
`default_nettype none

package core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [31:0] imm_t;

  // only the kept subset of rv32i
  typedef enum logic [6:0] {
    opc_load   = 7'b0000011,
    opc_op_imm = 7'b0010011,
    opc_store  = 7'b0100011,
    opc_op     = 7'b0110011,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111,
    opc_system = 7'b1110011
  } opcode_t;

  typedef enum logic [2:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt
  } alu_op_t;

  typedef enum logic [1:0] { src_a_pc, src_a_old_pc, src_a_reg } alu_src_a_t;
  typedef enum logic [1:0] { src_b_reg, src_b_imm, src_b_four } alu_src_b_t;
  typedef enum logic [1:0] { res_alu_out, res_mem_data, res_alu_result } result_src_t;
  typedef enum logic       { adr_pc, adr_result } adr_src_t;

  typedef enum logic [3:0] {
    st_idle, st_fetch, st_decode, st_mem_addr, st_mem_read, st_mem_wb,
    st_mem_write, st_execute, st_alu_wb, st_branch, st_jal, st_halt
  } fsm_state_t;

  typedef struct packed {
    logic        pc_update;
    logic        ir_write;
    logic        reg_write;
    logic        mem_write;
    adr_src_t    adr_src;
    alu_src_a_t  alu_src_a;
    alu_src_b_t  alu_src_b;
    result_src_t result_src;
    logic        alu_use_add;
    logic        retire;
  } ctrl_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [15:0] paddr;
    word_t       pwdata;
  } apb_req_t;

  typedef struct packed {
    word_t prdata;
    logic  pslverr;
  } apb_rsp_t;

endpackage

`default_nettype wire

// File: source/control_fsm.sv
`default_nettype none

module control_fsm import core_pkg::*; (
  input  wire          clk,
  input  wire          arst_n,
  input  wire          start,
  input  wire opcode_t opcode,
  input  wire [2:0]    funct3,
  input  wire          zero_flag,
  output ctrl_t        ctrl,
  output logic         halt
);

  fsm_state_t state;
  fsm_state_t state_nxt;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  ////////////////////
  // per-state control

  always_comb begin
    ctrl      = '0;
    state_nxt = state;
    case (state)
      st_idle: begin
        if (start) begin
          state_nxt = st_fetch;
        end
      end
      st_fetch: begin
        // memory read of pc, pc <= pc + 4
        ctrl.ir_write    = 1'b1;
        ctrl.adr_src     = adr_pc;
        ctrl.alu_src_a   = src_a_pc;
        ctrl.alu_src_b   = src_b_four;
        ctrl.alu_use_add = 1'b1;
        ctrl.result_src  = res_alu_result;
        ctrl.pc_update   = 1'b1;
        state_nxt        = st_decode;
      end
      st_decode: begin
        // branch and jal target into alu_out
        ctrl.alu_src_a   = src_a_old_pc;
        ctrl.alu_src_b   = src_b_imm;
        ctrl.alu_use_add = 1'b1;
        case (opcode)
          opc_load, opc_store: state_nxt = st_mem_addr;
          opc_op, opc_op_imm:  state_nxt = st_execute;
          opc_branch:          state_nxt = st_branch;
          opc_jal:             state_nxt = st_jal;
          opc_system: begin
            ctrl.retire = 1'b1;
            state_nxt   = st_halt;
          end
          default:             state_nxt = st_halt;
        endcase
      end
      st_mem_addr: begin
        ctrl.alu_src_a   = src_a_reg;
        ctrl.alu_src_b   = src_b_imm;
        ctrl.alu_use_add = 1'b1;
        ctrl.adr_src     = adr_result;
        ctrl.result_src  = res_alu_result;
        state_nxt        = (opcode == opc_load) ? st_mem_read : st_mem_write;
      end
      st_mem_read: begin
        state_nxt = st_mem_wb;
      end
      st_mem_wb: begin
        ctrl.result_src = res_mem_data;
        ctrl.reg_write  = 1'b1;
        ctrl.retire     = 1'b1;
        state_nxt       = st_fetch;
      end
      st_mem_write: begin
        ctrl.adr_src    = adr_result;
        ctrl.result_src = res_alu_out;
        ctrl.mem_write  = 1'b1;
        ctrl.retire     = 1'b1;
        state_nxt       = st_fetch;
      end
      st_execute: begin
        ctrl.alu_src_a = src_a_reg;
        ctrl.alu_src_b = (opcode == opc_op) ? src_b_reg : src_b_imm;
        state_nxt      = st_alu_wb;
      end
      st_alu_wb: begin
        ctrl.result_src = res_alu_out;
        ctrl.reg_write  = 1'b1;
        ctrl.retire     = 1'b1;
        state_nxt       = st_fetch;
      end
      st_branch: begin
        // beq takes on zero, bne on nonzero
        ctrl.alu_src_a  = src_a_reg;
        ctrl.alu_src_b  = src_b_reg;
        ctrl.result_src = res_alu_out;
        ctrl.pc_update  = (funct3 == 3'b001) ? !zero_flag : zero_flag;
        ctrl.retire     = 1'b1;
        state_nxt       = st_fetch;
      end
      st_jal: begin
        // jump now, link value lands in alu_out
        ctrl.alu_src_a   = src_a_old_pc;
        ctrl.alu_src_b   = src_b_four;
        ctrl.alu_use_add = 1'b1;
        ctrl.result_src  = res_alu_out;
        ctrl.pc_update   = 1'b1;
        state_nxt        = st_alu_wb;
      end
      st_halt: begin
        state_nxt = st_idle;
      end
      default: begin
        state_nxt = st_idle;
      end
    endcase
  end

  assign halt = (state == st_halt);

  // the single memory port serves either the fetch or the store
  a_no_fetch_store: assert property (@(posedge clk) disable iff (!arst_n)
    !(ctrl.ir_write && ctrl.mem_write));

endmodule

`default_nettype wire

// File: source/instr_decode.sv
`default_nettype none

module instr_decode import core_pkg::*; (
  input  wire word_t instr,
  input  wire        force_add,
  output opcode_t    opcode,
  output logic [2:0] funct3,
  output reg_idx_t   rd,
  output reg_idx_t   rs1,
  output reg_idx_t   rs2,
  output imm_t       imm,
  output alu_op_t    alu_op
);

  assign opcode = opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign rd     = instr[11:7];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  // immediate by format
  always_comb begin
    case (opcode)
      opc_store:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      opc_branch: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                         instr[11:8], 1'b0};
      opc_jal:    imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                         instr[30:21], 1'b0};
      default:    imm = {{20{instr[31]}}, instr[31:20]};
    endcase
  end

  always_comb begin
    alu_op = alu_add;
    if (!force_add) begin
      case (opcode)
        opc_op, opc_op_imm: begin
          case (funct3)
            // funct7 bit 5 selects sub, register form only
            3'b000:  alu_op = (opcode == opc_op && instr[30]) ? alu_sub : alu_add;
            3'b010:  alu_op = alu_slt;
            3'b100:  alu_op = alu_xor;
            3'b110:  alu_op = alu_or;
            3'b111:  alu_op = alu_and;
            default: alu_op = alu_add;
          endcase
        end
        opc_branch: alu_op = alu_sub;
        default:    alu_op = alu_add;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/alu.sv
`default_nettype none

module alu import core_pkg::*; (
  input  wire word_t   a,
  input  wire word_t   b,
  input  wire alu_op_t op,
  output word_t        result,
  output logic         zero
);

  always_comb begin
    case (op)
      alu_add: result = a + b;
      alu_sub: result = a - b;
      alu_and: result = a & b;
      alu_or:  result = a | b;
      alu_xor: result = a ^ b;
      // signed compare
      alu_slt: result = {31'b0, $signed(a) < $signed(b)};
      default: result = a + b;
    endcase
  end

  // branch equality test rides on sub
  assign zero = (result == '0);

endmodule

`default_nettype wire

// File: source/register_file.sv
`default_nettype none

module register_file import core_pkg::*; (
  input  wire           clk,
  input  wire           arst_n,
  input  wire           we,
  input  wire reg_idx_t ra1,
  input  wire reg_idx_t ra2,
  input  wire reg_idx_t wa,
  input  wire word_t    wd,
  output word_t         rd1,
  output word_t         rd2
);

  word_t regs [32];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wa != '0)) begin
      // x0 never written, stays zero
      regs[wa] <= wd;
    end
  end

  assign rd1 = regs[ra1];
  assign rd2 = regs[ra2];

endmodule

`default_nettype wire

// File: source/unified_memory.sv
`default_nettype none

`include "core_defs.svh"

module unified_memory import core_pkg::*; (
  input  wire        clk,
  input  wire        running,
  input  wire addr_t core_addr,
  input  wire word_t core_wdata,
  input  wire        core_we,
  input  wire addr_t host_addr,
  input  wire word_t host_wdata,
  input  wire        host_we,
  output word_t      rdata
);

  localparam int unsigned idx_w = $clog2(`MEM_WORDS);

  word_t            mem [`MEM_WORDS];
  addr_t            addr;
  word_t            wdata;
  logic             we;
  logic [idx_w-1:0] idx;

  ////////////////////
  // port select

  // core owns the array only while running
  always_comb begin
    if (running) begin
      addr  = core_addr;
      wdata = core_wdata;
      we    = core_we;
    end else begin
      addr  = host_addr;
      wdata = host_wdata;
      we    = host_we;
    end
  end

  // byte address to word index
  assign idx = addr[idx_w+1:2];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[idx] <= wdata;
    end
    rdata <= mem[idx];
  end

  a_no_host_write_running: assert property (@(posedge clk) !(running && host_we));

endmodule

`default_nettype wire

// File: source/perf_counter.sv
`default_nettype none

module perf_counter import core_pkg::*; (
  input  wire   clk,
  input  wire   arst_n,
  input  wire   start,
  input  wire   retire,
  input  wire   halt,
  output logic  running,
  output logic  halted,
  output word_t cycles,
  output word_t retired
);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      running <= 1'b0;
      halted  <= 1'b0;
      cycles  <= '0;
      retired <= '0;
    end else if (start) begin
      running <= 1'b1;
      halted  <= 1'b0;
      cycles  <= '0;
      retired <= '0;
    end else begin
      // the halt cycle itself still counts
      if (running) begin
        cycles <= cycles + 32'd1;
      end
      if (retire) begin
        retired <= retired + 32'd1;
      end
      if (halt) begin
        running <= 1'b0;
        halted  <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/core_top.sv
`default_nettype none

`include "core_defs.svh"

module core_top import core_pkg::*; (
  input  wire           clk,
  input  wire           arst_n,
  input  wire apb_req_t apb_req,
  output apb_rsp_t      apb_rsp
);

  localparam addr_t mem_bytes = `MEM_WORDS * 4;

  ctrl_t    ctrl;
  logic     halt;
  logic     running;
  logic     halted;
  word_t    cycles;
  word_t    retired;
  addr_t    pc;
  addr_t    old_pc;
  word_t    ir;
  logic     ir_pending;
  word_t    data_q;
  word_t    alu_out;
  word_t    reg_a;
  word_t    reg_b;
  word_t    instr;
  opcode_t  opcode;
  logic [2:0] funct3;
  reg_idx_t rd;
  reg_idx_t rs1;
  reg_idx_t rs2;
  imm_t     imm;
  alu_op_t  alu_op;
  word_t    rd1;
  word_t    rd2;
  word_t    src_a;
  word_t    src_b;
  word_t    alu_result;
  logic     zero_flag;
  word_t    result;
  addr_t    mem_addr;
  word_t    rdata;
  addr_t    host_addr;
  logic     apb_access;
  logic     is_mem;
  logic     is_ctrl;
  logic     is_stat;
  logic     is_cyc;
  logic     is_ret;
  logic     unmapped;
  logic     read_only;
  logic     start;
  logic     host_we;
  word_t    prdata;
  logic     pslverr;

  ////////////////////
  // datapath registers

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc         <= '0;
      ir_pending <= 1'b0;
    end else begin
      ir_pending <= ctrl.ir_write;
      if (start) begin
        pc <= '0;
      end else if (ctrl.pc_update) begin
        pc <= result;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.ir_write) begin
      old_pc <= pc;
    end
    if (ir_pending) begin
      ir <= rdata;
    end
    data_q  <= rdata;
    alu_out <= alu_result;
    reg_a   <= rd1;
    reg_b   <= rd2;
  end

  // fetched word arrives one cycle after the fetch step
  assign instr = ir_pending ? rdata : ir;

  ////////////////////
  // datapath muxes

  always_comb begin
    case (ctrl.adr_src)
      adr_pc:     mem_addr = pc;
      adr_result: mem_addr = result;
      default:    mem_addr = pc;
    endcase
  end

  always_comb begin
    case (ctrl.alu_src_a)
      src_a_pc:     src_a = pc;
      src_a_old_pc: src_a = old_pc;
      src_a_reg:    src_a = reg_a;
      default:      src_a = '0;
    endcase
  end

  always_comb begin
    case (ctrl.alu_src_b)
      src_b_reg:  src_b = reg_b;
      src_b_imm:  src_b = imm;
      src_b_four: src_b = 32'd4;
      default:    src_b = '0;
    endcase
  end

  always_comb begin
    case (ctrl.result_src)
      res_alu_out:    result = alu_out;
      res_mem_data:   result = data_q;
      res_alu_result: result = alu_result;
      default:        result = alu_out;
    endcase
  end

  ////////////////////
  // apb register decode

  assign host_addr  = {16'b0, apb_req.paddr};
  assign apb_access = apb_req.psel && apb_req.penable;
  assign is_mem     = (host_addr < mem_bytes);
  assign is_ctrl    = (host_addr == `CTRL_ADDR);
  assign is_stat    = (host_addr == `STAT_ADDR);
  assign is_cyc     = (host_addr == `CYC_ADDR);
  assign is_ret     = (host_addr == `RET_ADDR);
  assign read_only  = is_stat || is_cyc || is_ret;
  assign unmapped   = !(is_mem || is_ctrl || read_only);

  assign pslverr = apb_access && ((is_mem && running) || unmapped ||
                                  (apb_req.pwrite && read_only));
  assign host_we = apb_access && apb_req.pwrite && is_mem && !running;
  assign start   = apb_access && apb_req.pwrite && is_ctrl && apb_req.pwdata[0] && !running;

  // memory was addressed in the setup phase
  always_comb begin
    prdata = '0;
    if (is_mem) begin
      prdata = rdata;
    end else if (is_ctrl) begin
      prdata = {31'b0, running};
    end else if (is_stat) begin
      prdata = {30'b0, running, halted};
    end else if (is_cyc) begin
      prdata = cycles;
    end else if (is_ret) begin
      prdata = retired;
    end
  end

  assign apb_rsp = '{prdata: prdata, pslverr: pslverr};

  ////////////////////
  // instances

  control_fsm fsm0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .start     (start),
    .opcode    (opcode),
    .funct3    (funct3),
    .zero_flag (zero_flag),
    .ctrl      (ctrl),
    .halt      (halt)
  );

  instr_decode dec0 (
    .instr     (instr),
    .force_add (ctrl.alu_use_add),
    .opcode    (opcode),
    .funct3    (funct3),
    .rd        (rd),
    .rs1       (rs1),
    .rs2       (rs2),
    .imm       (imm),
    .alu_op    (alu_op)
  );

  alu alu0 (
    .a      (src_a),
    .b      (src_b),
    .op     (alu_op),
    .result (alu_result),
    .zero   (zero_flag)
  );

  register_file rf0 (
    .clk    (clk),
    .arst_n (arst_n),
    .we     (ctrl.reg_write),
    .ra1    (rs1),
    .ra2    (rs2),
    .wa     (rd),
    .wd     (result),
    .rd1    (rd1),
    .rd2    (rd2)
  );

  unified_memory mem0 (
    .clk        (clk),
    .running    (running),
    .core_addr  (mem_addr),
    .core_wdata (reg_b),
    .core_we    (ctrl.mem_write),
    .host_addr  (host_addr),
    .host_wdata (apb_req.pwdata),
    .host_we    (host_we),
    .rdata      (rdata)
  );

  perf_counter perf0 (
    .clk     (clk),
    .arst_n  (arst_n),
    .start   (start),
    .retire  (ctrl.retire),
    .halt    (halt),
    .running (running),
    .halted  (halted),
    .cycles  (cycles),
    .retired (retired)
  );

endmodule

`default_nettype wire

// File: verification/tb_core.sv
`default_nettype none

`include "core_defs.svh"

module tb_core import core_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  typedef enum logic [1:0] { k_write, k_read_check, k_start, k_wait_halt } op_kind_t;

  typedef struct packed {
    op_kind_t kind;
    addr_t    addr;
    word_t    data;
    word_t    expected;
    logic     err;
  } op_row_t;

  // cycles per instruction class
  localparam int cyc_alu      = 4;
  localparam int cyc_lw       = 5;
  localparam int cyc_sw       = 4;
  localparam int cyc_branch   = 3;
  localparam int cyc_jal      = 4;
  localparam int cyc_ecall    = 3;
  localparam int reset_cycles = 8;
  localparam int loop_n       = 5;

  // data area of the program
  localparam int a_addr    = 'h400;
  localparam int b_addr    = 'h404;
  localparam int res_addr  = 'h410;
  localparam int skip_addr = 'h440;
  localparam int jump_addr = 'h444;
  localparam int zero_addr = 'h448;
  localparam int fill_addr = 'h800;

  logic     clk;
  logic     arst_n;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;

  word_t   lfsr;
  word_t   op_a;
  word_t   op_b;
  word_t   prog[$];
  op_row_t ops[$];
  word_t   exp_res[9];
  int      exp_cycles;
  int      exp_retired;
  int      cycle_count;
  int      cycle_limit;

  core_top dut0 (
    .clk     (clk),
    .arst_n  (arst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Done: errors found");
      $fatal(1, "simulation timeout");
    end
  end

  ////////////////////
  // stimulus helpers

  // galois lfsr stepped once per bit
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ 32'h8020_0003;
    end
    return b;
  endfunction

  function automatic word_t random_word();
    word_t w;
    w = '0;
    for (int k = 0; k < 32; k++) begin
      w = {w[30:0], lfsr_bit()};
    end
    return w;
  endfunction

  function automatic word_t pattern_of(input addr_t addr);
    return addr ^ 32'hA5C3_5A3C;
  endfunction

  function automatic word_t r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                   input logic [2:0] f3, input int rd);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
  endfunction

  function automatic word_t i_type(input int imm, input int rs1, input logic [2:0] f3,
                                   input int rd, input logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
  endfunction

  function automatic word_t s_type(input int imm, input int rs2, input int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t b_type(input int imm, input int rs2, input int rs1,
                                   input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic word_t j_type(input int imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
  endfunction

  // times is how often the instruction executes
  task automatic emit(input word_t instr, input int cycles, input int times);
    prog.push_back(instr);
    exp_cycles  += cycles * times;
    exp_retired += times;
  endtask

  task automatic add_row(input op_kind_t kind, input addr_t addr, input word_t data,
                         input word_t expected, input logic err);
    op_row_t row;
    row.kind     = kind;
    row.addr     = addr;
    row.data     = data;
    row.expected = expected;
    row.err      = err;
    ops.push_back(row);
  endtask

  task automatic build_program();
    int jal_pc;
    emit(i_type(a_addr, 0, 3'b010, 1, opc_load), cyc_lw, 1);
    emit(i_type(b_addr, 0, 3'b010, 2, opc_load), cyc_lw, 1);
    emit(r_type(7'h00, 2, 1, 3'b000, 3), cyc_alu, 1);
    emit(s_type(res_addr, 3, 0), cyc_sw, 1);
    emit(r_type(7'h20, 2, 1, 3'b000, 4), cyc_alu, 1);
    emit(s_type(res_addr + 4, 4, 0), cyc_sw, 1);
    emit(r_type(7'h00, 2, 1, 3'b111, 5), cyc_alu, 1);
    emit(s_type(res_addr + 8, 5, 0), cyc_sw, 1);
    emit(r_type(7'h00, 2, 1, 3'b110, 6), cyc_alu, 1);
    emit(s_type(res_addr + 12, 6, 0), cyc_sw, 1);
    emit(r_type(7'h00, 2, 1, 3'b100, 7), cyc_alu, 1);
    emit(s_type(res_addr + 16, 7, 0), cyc_sw, 1);
    emit(r_type(7'h00, 2, 1, 3'b010, 8), cyc_alu, 1);
    emit(s_type(res_addr + 20, 8, 0), cyc_sw, 1);
    emit(i_type(-300, 1, 3'b000, 9, opc_op_imm), cyc_alu, 1);
    emit(s_type(res_addr + 24, 9, 0), cyc_sw, 1);
    // counting loop takes x10 up to x11
    emit(i_type(0, 0, 3'b000, 10, opc_op_imm), cyc_alu, 1);
    emit(i_type(loop_n, 0, 3'b000, 11, opc_op_imm), cyc_alu, 1);
    emit(i_type(1, 10, 3'b000, 10, opc_op_imm), cyc_alu, loop_n);
    emit(b_type(-4, 11, 10, 3'b001), cyc_branch, loop_n);
    emit(s_type(res_addr + 28, 10, 0), cyc_sw, 1);
    // taken beq over a store
    emit(b_type(8, 0, 0, 3'b000), cyc_branch, 1);
    emit(s_type(skip_addr, 1, 0), cyc_sw, 0);
    jal_pc = 4 * prog.size();
    emit(j_type(8, 12), cyc_jal, 1);
    emit(s_type(jump_addr, 1, 0), cyc_sw, 0);
    emit(s_type(res_addr + 32, 12, 0), cyc_sw, 1);
    emit(i_type(55, 0, 3'b000, 0, opc_op_imm), cyc_alu, 1);
    emit(s_type(zero_addr, 0, 0), cyc_sw, 1);
    emit(32'h0000_0073, cyc_ecall, 1);

    exp_res[0] = op_a + op_b;
    exp_res[1] = op_a - op_b;
    exp_res[2] = op_a & op_b;
    exp_res[3] = op_a | op_b;
    exp_res[4] = op_a ^ op_b;
    exp_res[5] = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
    exp_res[6] = op_a - 32'd300;
    exp_res[7] = loop_n;
    exp_res[8] = jal_pc + 4;
  endtask

  task automatic build_table();
    // host access while the core is stopped
    for (int k = 0; k < 4; k++) begin
      add_row(k_write, fill_addr + 4 * k, pattern_of(fill_addr + 4 * k), '0, 1'b0);
    end
    for (int k = 0; k < 4; k++) begin
      add_row(k_read_check, fill_addr + 4 * k, '0, pattern_of(fill_addr + 4 * k), 1'b0);
    end
    add_row(k_read_check, 'h2000, '0, '0, 1'b1);
    add_row(k_write, 'h2004, 32'h1, '0, 1'b1);
    add_row(k_write, `STAT_ADDR, 32'h3, '0, 1'b1);
    add_row(k_read_check, `STAT_ADDR, '0, '0, 1'b0);

    for (int i = 0; i < prog.size(); i++) begin
      add_row(k_write, 4 * i, prog[i], '0, 1'b0);
    end
    add_row(k_write, a_addr, op_a, '0, 1'b0);
    add_row(k_write, b_addr, op_b, '0, 1'b0);
    add_row(k_write, skip_addr, pattern_of(skip_addr), '0, 1'b0);
    add_row(k_write, jump_addr, pattern_of(jump_addr), '0, 1'b0);
    add_row(k_write, zero_addr, 32'hFFFF_FFFF, '0, 1'b0);

    add_row(k_start, `CTRL_ADDR, 32'd1, '0, 1'b0);
    add_row(k_read_check, a_addr, '0, '0, 1'b1);
    add_row(k_wait_halt, `STAT_ADDR, '0, '0, 1'b0);

    for (int k = 0; k < 9; k++) begin
      add_row(k_read_check, res_addr + 4 * k, '0, exp_res[k], 1'b0);
    end
    add_row(k_read_check, skip_addr, '0, pattern_of(skip_addr), 1'b0);
    add_row(k_read_check, jump_addr, '0, pattern_of(jump_addr), 1'b0);
    add_row(k_read_check, zero_addr, '0, '0, 1'b0);
    add_row(k_read_check, `STAT_ADDR, '0, 32'd1, 1'b0);
    add_row(k_read_check, `CYC_ADDR, '0, exp_cycles, 1'b0);
    add_row(k_read_check, `RET_ADDR, '0, exp_retired, 1'b0);
  endtask

  ////////////////////
  // apb driver

  task automatic apb_write(input addr_t addr, input word_t data, output logic err);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b1;
    apb_req.paddr   = addr[15:0];
    apb_req.pwdata  = data;
    @(posedge clk);
    #1;
    apb_req.penable = 1'b1;
    @(negedge clk);
    err = apb_rsp.pslverr;
    @(posedge clk);
    #1;
    apb_req = '0;
  endtask

  task automatic apb_read(input addr_t addr, output word_t data, output logic err);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
    apb_req.paddr   = addr[15:0];
    apb_req.pwdata  = '0;
    @(posedge clk);
    #1;
    apb_req.penable = 1'b1;
    // prdata settled in the access phase
    @(negedge clk);
    data = apb_rsp.prdata;
    err  = apb_rsp.pslverr;
    @(posedge clk);
    #1;
    apb_req = '0;
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
      $display("Done: errors found");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  ////////////////////
  // main sequence

  initial begin
    op_row_t row;
    word_t   rdata;
    logic    err;
    clk         = 1'b0;
    arst_n      = 1'b0;
    apb_req     = '0;
    lfsr        = 32'd3;
    exp_cycles  = 0;
    exp_retired = 0;
    cycle_count = 0;
    op_a        = random_word();
    op_b        = random_word();
    build_program();
    build_table();
    cycle_limit = 2 * exp_cycles + 2 * ops.size() + reset_cycles;

    repeat (reset_cycles) @(posedge clk);
    #1;
    arst_n = 1'b1;

    for (int i = 0; i < ops.size(); i++) begin
      row = ops[i];
      case (row.kind)
        k_write, k_start: begin
          apb_write(row.addr, row.data, err);
          check_word({31'b0, err}, {31'b0, row.err},
                     $sformatf("pslverr, row %0d write to %h", i, row.addr));
        end
        k_read_check: begin
          apb_read(row.addr, rdata, err);
          check_word({31'b0, err}, {31'b0, row.err},
                     $sformatf("pslverr, row %0d read of %h", i, row.addr));
          if (!row.err) begin
            check_word(rdata, row.expected,
                       $sformatf("data, row %0d read of %h", i, row.addr));
          end
        end
        k_wait_halt: begin
          // poll until the halted flag shows
          rdata = '0;
          while (!rdata[0]) begin
            apb_read(row.addr, rdata, err);
            check_word({31'b0, err}, 32'd0, "pslverr on status poll");
          end
        end
      endcase
    end

    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+source
source/core_pkg.sv
source/control_fsm.sv
source/instr_decode.sv
source/alu.sv
source/register_file.sv
source/unified_memory.sv
source/perf_counter.sv
source/core_top.sv
verification/tb_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_core -f list.f -o tb_core_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_core_sim
if [ $? -ne 0 ]; then
  echo "simulation failed"
  exit 1
fi

echo "simulation passed"
exit 0
